//--- src/sb_pkg.sv
// sizes, vector types and the commit state for the register-valid scoreboard
// ROB_ENTRIES must stay a power of two because the queue pointers wrap by overflow
// register 0 is hardwired valid and is never renamed
package sb_pkg;

	// ============================================================
	// sizes
	// ============================================================

	// architectural registers tracked by the valid bits
	localparam int NUM_AREGS   = 32;
	// depth of the reorder queue
	localparam int ROB_ENTRIES = 8;
	// dispatch slots per cycle, which is also the commit width
	localparam int NUM_SLOTS   = 2;

	// ============================================================
	// types
	// ============================================================

	// architectural register number
	typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;

	// reorder queue tag
	typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_id_t;

	// occupancy is one bit wider than a tag so that a full queue can be counted
	typedef logic [$clog2(ROB_ENTRIES):0] rob_cnt_t;

	// one bit per architectural register
	typedef logic [NUM_AREGS-1:0] areg_mask_t;

	// commit_flush holds commit off for the cycle after a branch miss
	typedef enum logic {
		commit_run,
		commit_flush
	} commit_state_t;

endpackage

//--- src/rename_source_table.sv
// latest-writer table with one reorder tag per architectural register
// a register without an in-flight writer keeps a stale tag that is only read
// while that register is invalid, so the stale value never matches a commit
// during a branch miss the entry vectors must show only the surviving entries
`timescale 1ns/1ps

module rename_source_table import sb_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [NUM_SLOTS-1:0]   slot_v,
	input  logic [NUM_SLOTS-1:0]   slot_rfw,
	input  areg_t                  slot_rd0,
	input  areg_t                  slot_rd1,
	input  rob_id_t                dispatch_id0,
	input  rob_id_t                dispatch_id1,
	input  logic                   branchmiss,
	input  logic [ROB_ENTRIES-1:0] ent_live,
	input  logic [ROB_ENTRIES-1:0] ent_rfw,
	input  areg_t                  ent_tgt [ROB_ENTRIES],
	input  rob_id_t                ent_id [ROB_ENTRIES],
	output rob_id_t                rf_source [NUM_AREGS]
);

	// youngest surviving writer of each register, found by the rebuild scan
	rob_id_t    scan_tag [NUM_AREGS];
	areg_mask_t scan_hit;

	// ============================================================
	// rebuild scan
	// ============================================================

	always_comb begin
		for (int r = 0; r < NUM_AREGS; r++) begin
			scan_tag[r] = '0;
			scan_hit[r] = 1'b0;
			// entries arrive oldest first so the last match is the youngest writer
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				if (ent_live[i] && ent_rfw[i] && ent_tgt[i] == areg_t'(r)) begin
					scan_tag[r] = ent_id[i];
					scan_hit[r] = 1'b1;
				end
			end
		end
	end

	// ============================================================
	// table update
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < NUM_AREGS; r++) begin
				rf_source[r] <= '0;
			end
		end else if (branchmiss) begin
			// dispatch is dropped in a miss cycle so only the rebuild writes
			for (int r = 1; r < NUM_AREGS; r++) begin
				if (scan_hit[r]) begin
					rf_source[r] <= scan_tag[r];
				end
			end
		end else begin
			if (slot_v[0] && slot_rfw[0] && slot_rd0 != '0) begin
				rf_source[slot_rd0] <= dispatch_id0;
			end
			// slot 1 is younger and comes second, so it wins on a shared target
			if (slot_v[1] && slot_rfw[1] && slot_rd1 != '0) begin
				rf_source[slot_rd1] <= dispatch_id1;
			end
		end
	end

endmodule

//--- src/reorder_queue.sv
// circular reorder queue of in-flight instructions
// dispatch_ready needs two free entries and slot 1 is only used with slot 0
// a completion for a dead entry is dropped, and miss_id must name a live entry
// the entry vectors and live_target already exclude entries flushed this cycle
`timescale 1ns/1ps

module reorder_queue import sb_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [NUM_SLOTS-1:0]       slot_v,
	input  logic [NUM_SLOTS-1:0]       slot_rfw,
	input  areg_t                      slot_rd0,
	input  areg_t                      slot_rd1,
	input  logic                       complete_v,
	input  rob_id_t                    complete_id,
	input  logic                       branchmiss,
	input  rob_id_t                    miss_id,
	input  logic [$clog2(NUM_SLOTS):0] commit_cnt,
	output logic                       dispatch_ready,
	output rob_id_t                    dispatch_id0,
	output rob_id_t                    dispatch_id1,
	output rob_id_t                    head_id,
	output logic [NUM_SLOTS-1:0]       head_done,
	output logic [NUM_SLOTS-1:0]       head_rfw,
	output areg_t                      head_tgt0,
	output areg_t                      head_tgt1,
	output logic [ROB_ENTRIES-1:0]     ent_live,
	output logic [ROB_ENTRIES-1:0]     ent_rfw,
	output areg_t                      ent_tgt [ROB_ENTRIES],
	output rob_id_t                    ent_id [ROB_ENTRIES],
	output areg_mask_t                 live_target
);

	rob_id_t                head_q;
	rob_id_t                tail_q;
	rob_cnt_t               count_q;
	areg_t                  tgt_q [ROB_ENTRIES];
	logic [ROB_ENTRIES-1:0] rfw_q;
	logic [ROB_ENTRIES-1:0] done_q;
	logic [ROB_ENTRIES-1:0] live_q;
	// live entries that also survive this cycle's branch miss, indexed by tag
	logic [ROB_ENTRIES-1:0] surv;
	rob_id_t                miss_age;
	rob_id_t                head_nxt1;
	rob_cnt_t               alloc_cnt;

	assign dispatch_ready = count_q <= rob_cnt_t'(ROB_ENTRIES - NUM_SLOTS);
	assign dispatch_id0   = tail_q;
	assign dispatch_id1   = tail_q + rob_id_t'(1);
	assign alloc_cnt      = rob_cnt_t'(slot_v[0]) + rob_cnt_t'(slot_v[1]);

	// the two oldest entries feed the commit selector
	assign head_id   = head_q;
	assign head_nxt1 = head_q + rob_id_t'(1);
	assign head_done = {done_q[head_nxt1] & live_q[head_nxt1], done_q[head_q] & live_q[head_q]};
	assign head_rfw  = {rfw_q[head_nxt1], rfw_q[head_q]};
	assign head_tgt0 = tgt_q[head_q];
	assign head_tgt1 = tgt_q[head_nxt1];

	// distance of the missed entry from the head
	assign miss_age = miss_id - head_q;

	always_comb begin
		rob_id_t age;
		rob_id_t idx;
		surv        = live_q;
		live_target = '0;
		for (int k = 0; k < ROB_ENTRIES; k++) begin
			age = rob_id_t'(k) - head_q;
			// anything younger than the missed entry is flushed
			if (branchmiss && age > miss_age) begin
				surv[k] = 1'b0;
			end
			if (surv[k] && rfw_q[k]) begin
				live_target[tgt_q[k]] = 1'b1;
			end
		end
		// age-ordered view for the source table rebuild
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			idx         = head_q + rob_id_t'(i);
			ent_id[i]   = idx;
			ent_live[i] = surv[idx];
			ent_rfw[i]  = rfw_q[idx];
			ent_tgt[i]  = tgt_q[idx];
		end
	end

	// ============================================================
	// queue state
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			live_q  <= '0;
		end else if (branchmiss) begin
			// commit and dispatch are both off, so only the tail moves back
			live_q  <= surv;
			tail_q  <= miss_id + rob_id_t'(1);
			count_q <= rob_cnt_t'(miss_age) + rob_cnt_t'(1);
			if (complete_v && surv[complete_id]) begin
				done_q[complete_id] <= 1'b1;
			end
		end else begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				if (i < int'(commit_cnt)) begin
					live_q[head_q + rob_id_t'(i)] <= 1'b0;
				end
			end
			head_q  <= head_q + rob_id_t'(commit_cnt);
			tail_q  <= tail_q + rob_id_t'(alloc_cnt);
			count_q <= count_q + alloc_cnt - rob_cnt_t'(commit_cnt);
			if (complete_v && live_q[complete_id]) begin
				done_q[complete_id] <= 1'b1;
			end
			// the free entries at the tail never overlap the retiring head
			if (slot_v[0]) begin
				live_q[dispatch_id0] <= 1'b1;
				done_q[dispatch_id0] <= 1'b0;
				rfw_q[dispatch_id0]  <= slot_rfw[0];
				tgt_q[dispatch_id0]  <= slot_rd0;
			end
			if (slot_v[1]) begin
				live_q[dispatch_id1] <= 1'b1;
				done_q[dispatch_id1] <= 1'b0;
				rfw_q[dispatch_id1]  <= slot_rfw[1];
				tgt_q[dispatch_id1]  <= slot_rd1;
			end
		end
	end

	// the environment holds dispatch off while fewer than two entries are free
	a_dispatch_ready: assert property (@(posedge clk) disable iff (rst)
		|slot_v |-> dispatch_ready);

	// allocation and retirement together never push the count past the depth
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		|slot_v |=> count_q <= rob_cnt_t'(ROB_ENTRIES));

	// a branch miss always names an instruction that is still in flight
	a_miss_live: assert property (@(posedge clk) disable iff (rst)
		branchmiss |-> live_q[miss_id]);

endmodule

//--- src/commit_select.sv
// in-order commit of up to two done entries from the queue head
// the second entry only commits together with the first
// nothing commits in a branch-miss cycle or in the cycle after it
// commit valids mark register writers only, commit_cnt counts every entry
`timescale 1ns/1ps

module commit_select import sb_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       branchmiss,
	input  rob_id_t                    head_id,
	input  logic [NUM_SLOTS-1:0]       head_done,
	input  logic [NUM_SLOTS-1:0]       head_rfw,
	input  areg_t                      head_tgt0,
	input  areg_t                      head_tgt1,
	output logic                       commit0_v,
	output rob_id_t                    commit0_id,
	output areg_t                      commit0_tgt,
	output logic                       commit1_v,
	output rob_id_t                    commit1_id,
	output areg_t                      commit1_tgt,
	output logic [$clog2(NUM_SLOTS):0] commit_cnt
);

	commit_state_t state_q;
	logic          take0;
	logic          take1;

	// a miss moves to commit_flush for exactly one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= commit_run;
		end else if (branchmiss) begin
			state_q <= commit_flush;
		end else begin
			state_q <= commit_run;
		end
	end

	// retirement stays in order, so entry 1 needs entry 0 to go too
	assign take0 = state_q == commit_run && !branchmiss && head_done[0];
	assign take1 = take0 && head_done[1];

	assign commit_cnt = {1'b0, take0} + {1'b0, take1};

	assign commit0_v   = take0 && head_rfw[0];
	assign commit0_id  = head_id;
	assign commit0_tgt = head_tgt0;
	assign commit1_v   = take1 && head_rfw[1];
	assign commit1_id  = head_id + rob_id_t'(1);
	assign commit1_tgt = head_tgt1;

endmodule

//--- src/reg_valid_tracker.sv
// valid bit per architectural register, plus an advance view for read-through
// reg_is_valid is the next rf_v before this cycle's dispatch clears are applied
// a commit revalidates only when its tag is still the register's latest writer
// dispatch invalidation wins over a commit to the same register
`timescale 1ns/1ps

module reg_valid_tracker import sb_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [NUM_SLOTS-1:0] slot_v,
	input  logic [NUM_SLOTS-1:0] slot_rfw,
	input  areg_t                slot_rd0,
	input  areg_t                slot_rd1,
	input  logic                 commit0_v,
	input  rob_id_t              commit0_id,
	input  areg_t                commit0_tgt,
	input  logic                 commit1_v,
	input  rob_id_t              commit1_id,
	input  areg_t                commit1_tgt,
	input  rob_id_t              rf_source [NUM_AREGS],
	input  logic                 branchmiss,
	input  areg_mask_t           live_target,
	output areg_mask_t           rf_v,
	output areg_mask_t           reg_is_valid
);

	areg_mask_t rf_v_nxt;

	// ============================================================
	// advance view
	// ============================================================

	always_comb begin
		reg_is_valid = rf_v;
		// registers left without a surviving writer hold committed data
		if (branchmiss) begin
			reg_is_valid = rf_v | ~live_target;
		end
		// the source may have moved on to a younger writer since dispatch
		if (commit0_v && !rf_v[commit0_tgt]) begin
			reg_is_valid[commit0_tgt] = rf_source[commit0_tgt] == commit0_id;
		end
		// commit 1 is younger, so on a shared target its result stands
		if (commit1_v && !rf_v[commit1_tgt]) begin
			reg_is_valid[commit1_tgt] = rf_source[commit1_tgt] == commit1_id;
		end
		reg_is_valid[0] = 1'b1;
	end

	// ============================================================
	// registered valid bits
	// ============================================================

	always_comb begin
		rf_v_nxt = reg_is_valid;
		// dispatch is ignored in a miss cycle and leaves the bits alone
		if (!branchmiss) begin
			if (slot_v[0] && slot_rfw[0]) begin
				rf_v_nxt[slot_rd0] = 1'b0;
			end
			if (slot_v[1] && slot_rfw[1]) begin
				rf_v_nxt[slot_rd1] = 1'b0;
			end
		end
		rf_v_nxt[0] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rf_v <= '1;
		end else begin
			rf_v <= rf_v_nxt;
		end
	end

	// register 0 reads as valid in both views at all times
	a_reg0_valid: assert property (@(posedge clk) disable iff (rst)
		rf_v[0] && reg_is_valid[0]);

endmodule

//--- src/scoreboard_top.sv
// register-valid scoreboard for a two-wide out-of-order core
// dispatch, completion and branch miss are single-cycle strobes with no handshake
// the environment must respect dispatch_ready and keep miss_id on a live entry
`timescale 1ns/1ps

module scoreboard_top import sb_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	// dispatch, slot 0 is the older instruction
	input  logic [NUM_SLOTS-1:0] slot_v,
	input  logic [NUM_SLOTS-1:0] slot_rfw,
	input  areg_t                slot_rd0,
	input  areg_t                slot_rd1,
	// completion
	input  logic                 complete_v,
	input  rob_id_t              complete_id,
	// branch miss
	input  logic                 branchmiss,
	input  rob_id_t              miss_id,
	output logic                 dispatch_ready,
	output rob_id_t              dispatch_id0,
	output rob_id_t              dispatch_id1,
	output logic                 commit0_v,
	output rob_id_t              commit0_id,
	output areg_t                commit0_tgt,
	output logic                 commit1_v,
	output rob_id_t              commit1_id,
	output areg_t                commit1_tgt,
	output areg_mask_t           rf_v,
	output areg_mask_t           reg_is_valid
);

	// ============================================================
	// block interconnect
	// ============================================================

	// head of the queue toward the commit selector
	logic [$clog2(NUM_SLOTS):0] commit_cnt;
	rob_id_t                    head_id;
	logic [NUM_SLOTS-1:0]       head_done;
	logic [NUM_SLOTS-1:0]       head_rfw;
	areg_t                      head_tgt0;
	areg_t                      head_tgt1;
	// surviving entries in age order for the source table rebuild
	logic [ROB_ENTRIES-1:0]     ent_live;
	logic [ROB_ENTRIES-1:0]     ent_rfw;
	areg_t                      ent_tgt [ROB_ENTRIES];
	rob_id_t                    ent_id [ROB_ENTRIES];
	areg_mask_t                 live_target;
	rob_id_t                    rf_source [NUM_AREGS];

	// every port name matches its wire, so the blocks connect by name
	rename_source_table u_rename_source_table (.*);

	reorder_queue u_reorder_queue (.*);

	commit_select u_commit_select (.*);

	reg_valid_tracker u_reg_valid_tracker (.*);

endmodule

//--- dv/scoreboard_model.svh
// reference model of the scoreboard, included into the body of the testbench module
// it depends on the sb_pkg import and on the input variables of that module
// predictions use the state left by the last edge plus the inputs of the current cycle
`ifndef SCOREBOARD_MODEL_SVH
`define SCOREBOARD_MODEL_SVH

// ============================================================
// model state
// ============================================================

rob_id_t       ref_head;
rob_id_t       ref_tail;
int            ref_count;
logic          ref_live [ROB_ENTRIES];
logic          ref_done [ROB_ENTRIES];
logic          ref_rfw [ROB_ENTRIES];
areg_t         ref_tgt [ROB_ENTRIES];
// latest writer of each register
rob_id_t       ref_src [NUM_AREGS];
areg_mask_t    ref_rfv;
commit_state_t ref_state;

// expected outputs of the current cycle
logic          exp_ready;
logic          exp_take0;
logic          exp_take1;
logic          exp_c0_v;
rob_id_t       exp_c0_id;
areg_t         exp_c0_tgt;
logic          exp_c1_v;
rob_id_t       exp_c1_id;
areg_t         exp_c1_tgt;
areg_mask_t    exp_adv;

// position of a tag counted from the oldest entry
function automatic rob_id_t age_of(input rob_id_t tag);
	return tag - ref_head;
endfunction

task automatic reset_reference();
	ref_head  = '0;
	ref_tail  = '0;
	ref_count = 0;
	for (int k = 0; k < ROB_ENTRIES; k++) begin
		ref_live[k] = 1'b0;
		ref_done[k] = 1'b0;
		ref_rfw[k]  = 1'b0;
		ref_tgt[k]  = '0;
	end
	for (int r = 0; r < NUM_AREGS; r++) begin
		ref_src[r] = '0;
	end
	ref_rfv   = '1;
	ref_state = commit_run;
endtask

task automatic predict_outputs();
	rob_id_t    second;
	areg_mask_t writers;
	second    = ref_head + rob_id_t'(1);
	exp_ready = ref_count <= ROB_ENTRIES - NUM_SLOTS;
	// the head retires when done, the next one only together with it
	exp_take0 = ref_state == commit_run && !branchmiss && ref_live[ref_head] && ref_done[ref_head];
	exp_take1 = exp_take0 && ref_live[second] && ref_done[second];
	exp_c0_v   = exp_take0 && ref_rfw[ref_head];
	exp_c0_id  = ref_head;
	exp_c0_tgt = ref_tgt[ref_head];
	exp_c1_v   = exp_take1 && ref_rfw[second];
	exp_c1_id  = second;
	exp_c1_tgt = ref_tgt[second];
	exp_adv = ref_rfv;
	if (branchmiss) begin
		writers = '0;
		for (int k = 0; k < ROB_ENTRIES; k++) begin
			if (ref_live[k] && ref_rfw[k] && age_of(rob_id_t'(k)) <= age_of(miss_id)) begin
				writers[ref_tgt[k]] = 1'b1;
			end
		end
		// no surviving writer means the register holds committed data
		exp_adv = ref_rfv | ~writers;
	end
	if (exp_c0_v && !ref_rfv[exp_c0_tgt]) begin
		exp_adv[exp_c0_tgt] = ref_src[exp_c0_tgt] == exp_c0_id;
	end
	if (exp_c1_v && !ref_rfv[exp_c1_tgt]) begin
		exp_adv[exp_c1_tgt] = ref_src[exp_c1_tgt] == exp_c1_id;
	end
	exp_adv[0] = 1'b1;
endtask

// ============================================================
// one clock edge
// ============================================================

task automatic advance_reference();
	rob_id_t    tag;
	rob_id_t    keep_age;
	areg_mask_t next_rfv;
	int         retired;
	int         alloc;
	next_rfv = exp_adv;
	if (branchmiss) begin
		keep_age = age_of(miss_id);
		// walk oldest first so the youngest surviving writer ends up in the table
		for (int a = 0; a < ROB_ENTRIES; a++) begin
			tag = ref_head + rob_id_t'(a);
			if (a > int'(keep_age)) begin
				ref_live[tag] = 1'b0;
			end else if (ref_live[tag] && ref_rfw[tag] && ref_tgt[tag] != '0) begin
				ref_src[ref_tgt[tag]] = tag;
			end
		end
		if (complete_v && ref_live[complete_id]) begin
			ref_done[complete_id] = 1'b1;
		end
		ref_tail  = miss_id + rob_id_t'(1);
		ref_count = int'(keep_age) + 1;
		ref_state = commit_flush;
	end else begin
		if (complete_v && ref_live[complete_id]) begin
			ref_done[complete_id] = 1'b1;
		end
		retired = int'(exp_take0) + int'(exp_take1);
		if (exp_take0) begin
			ref_live[ref_head] = 1'b0;
		end
		if (exp_take1) begin
			ref_live[ref_head + rob_id_t'(1)] = 1'b0;
		end
		ref_head = ref_head + rob_id_t'(retired);
		alloc = 0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (slot_v[s]) begin
				tag = ref_tail + rob_id_t'(s);
				ref_live[tag] = 1'b1;
				ref_done[tag] = 1'b0;
				ref_rfw[tag]  = slot_rfw[s];
				ref_tgt[tag]  = (s == 0) ? slot_rd0 : slot_rd1;
				// a new writer invalidates its target even against a commit
				if (slot_rfw[s]) begin
					next_rfv[ref_tgt[tag]] = 1'b0;
					if (ref_tgt[tag] != '0) begin
						ref_src[ref_tgt[tag]] = tag;
					end
				end
				alloc++;
			end
		end
		ref_tail  = ref_tail + rob_id_t'(alloc);
		ref_count = ref_count - retired + alloc;
		ref_state = commit_run;
	end
	next_rfv[0] = 1'b1;
	ref_rfv = next_rfv;
endtask

`endif

//--- dv/scoreboard_tb.sv
// testbench for scoreboard_top against a cycle-stepped reference model
// inputs change 2 ns after the rising edge, outputs are sampled at the falling edge
// dispatch is only driven while the model says two entries are free
`timescale 1ns/1ps

module scoreboard_tb import sb_pkg::*; ();

	localparam int RUN_CYCLES  = 3000;
	localparam int DRAIN_LIMIT = 200;
	localparam int SEED        = 32'he71391bb;

	logic                 clk;
	logic                 rst;
	logic [NUM_SLOTS-1:0] slot_v;
	logic [NUM_SLOTS-1:0] slot_rfw;
	areg_t                slot_rd0;
	areg_t                slot_rd1;
	logic                 complete_v;
	rob_id_t              complete_id;
	logic                 branchmiss;
	rob_id_t              miss_id;
	logic                 dispatch_ready;
	rob_id_t              dispatch_id0;
	rob_id_t              dispatch_id1;
	logic                 commit0_v;
	rob_id_t              commit0_id;
	areg_t                commit0_tgt;
	logic                 commit1_v;
	rob_id_t              commit1_id;
	areg_t                commit1_tgt;
	areg_mask_t           rf_v;
	areg_mask_t           reg_is_valid;

	int checks;
	int errors;
	int n_commit;
	int n_revalid;
	int n_stale;
	int n_miss;

	`include "scoreboard_model.svh"

	scoreboard_top uut (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// ============================================================
	// checking
	// ============================================================

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s expected %0h actual %0h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic check_reset_state();
		check_value("reset rf_v", 32'hffff_ffff, 32'(rf_v));
		check_value("reset reg_is_valid", 32'hffff_ffff, 32'(reg_is_valid));
		check_value("reset dispatch_ready", 32'd1, 32'(dispatch_ready));
		check_value("reset commit0_v", 32'd0, 32'(commit0_v));
		check_value("reset commit1_v", 32'd0, 32'(commit1_v));
	endtask

	task automatic compare_outputs();
		rob_id_t next_tag;
		predict_outputs();
		next_tag = ref_tail + rob_id_t'(1);
		check_value("dispatch_ready", 32'(exp_ready), 32'(dispatch_ready));
		check_value("dispatch_id0", 32'(ref_tail), 32'(dispatch_id0));
		check_value("dispatch_id1", 32'(next_tag), 32'(dispatch_id1));
		check_value("commit0_v", 32'(exp_c0_v), 32'(commit0_v));
		check_value("commit1_v", 32'(exp_c1_v), 32'(commit1_v));
		// ids and targets only carry meaning while their valid is up
		if (exp_c0_v) begin
			check_value("commit0_id", 32'(exp_c0_id), 32'(commit0_id));
			check_value("commit0_tgt", 32'(exp_c0_tgt), 32'(commit0_tgt));
			n_commit++;
			if (!ref_rfv[exp_c0_tgt] && ref_src[exp_c0_tgt] == exp_c0_id) begin
				n_revalid++;
			end else if (!ref_rfv[exp_c0_tgt]) begin
				n_stale++;
			end
		end
		if (exp_c1_v) begin
			check_value("commit1_id", 32'(exp_c1_id), 32'(commit1_id));
			check_value("commit1_tgt", 32'(exp_c1_tgt), 32'(commit1_tgt));
			n_commit++;
			if (!ref_rfv[exp_c1_tgt] && ref_src[exp_c1_tgt] == exp_c1_id) begin
				n_revalid++;
			end else if (!ref_rfv[exp_c1_tgt]) begin
				n_stale++;
			end
		end
		check_value("rf_v", 32'(ref_rfv), 32'(rf_v));
		check_value("reg_is_valid", 32'(exp_adv), 32'(reg_is_valid));
		if (branchmiss) begin
			n_miss++;
		end
	endtask

	// ============================================================
	// stimulus
	// ============================================================

	task automatic idle_inputs();
		slot_v      = '0;
		slot_rfw    = '0;
		slot_rd0    = '0;
		slot_rd1    = '0;
		complete_v  = 1'b0;
		complete_id = '0;
		branchmiss  = 1'b0;
		miss_id     = '0;
	endtask

	// a narrow range keeps several writers of one register in flight
	function automatic areg_t pick_target();
		if ($urandom % 4 == 0) begin
			return areg_t'($urandom % NUM_AREGS);
		end
		return areg_t'($urandom % 6);
	endfunction

	task automatic choose_stimulus(input bit allow_new);
		int n;
		idle_inputs();
		if (allow_new && ref_count > 0 && $urandom % 16 == 0) begin
			branchmiss = 1'b1;
			miss_id    = ref_head + rob_id_t'($urandom % ref_count);
		end
		if (allow_new && ref_count <= ROB_ENTRIES - NUM_SLOTS) begin
			n = int'($urandom % 3);
			slot_v   = (n == 0) ? 2'b00 : (n == 1) ? 2'b01 : 2'b11;
			slot_rfw = {($urandom % 4 != 0), ($urandom % 4 != 0)};
			slot_rd0 = pick_target();
			slot_rd1 = pick_target();
		end
		if (ref_count > 0 && $urandom % 4 != 0) begin
			complete_v  = 1'b1;
			complete_id = ref_head + rob_id_t'($urandom % ref_count);
		end else if ($urandom % 8 == 0) begin
			// any tag at all, a dead one has to be dropped
			complete_v  = 1'b1;
			complete_id = rob_id_t'($urandom % ROB_ENTRIES);
		end
	endtask

	task automatic run_cycle(input bit allow_new);
		@(posedge clk);
		#2;
		choose_stimulus(allow_new);
		@(negedge clk);
		compare_outputs();
		advance_reference();
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		int waited;
		void'($urandom(SEED));
		checks    = 0;
		errors    = 0;
		n_commit  = 0;
		n_revalid = 0;
		n_stale   = 0;
		n_miss    = 0;
		waited    = 0;
		rst       = 1'b1;
		idle_inputs();
		reset_reference();
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		check_reset_state();
		compare_outputs();
		advance_reference();

		for (int c = 0; c < RUN_CYCLES; c++) begin
			run_cycle(1'b1);
		end

		// completions only, until every entry has retired
		while (ref_count > 0 && waited < DRAIN_LIMIT) begin
			run_cycle(1'b0);
			waited++;
		end
		if (ref_count > 0) begin
			errors++;
			$display("the queue still held %0d entries after %0d drain cycles",
				ref_count, DRAIN_LIMIT);
		end
		run_cycle(1'b0);
		check_value("drained rf_v", 32'hffff_ffff, 32'(rf_v));

		if (n_stale == 0 || n_revalid == 0 || n_miss == 0) begin
			errors++;
			$display("the random run missed a stale commit, a revalidating commit or a miss");
		end

		$display("checks %0d errors %0d commits %0d revalidated %0d stale %0d misses %0d",
			checks, errors, n_commit, n_revalid, n_stale, n_miss);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+dv
src/sb_pkg.sv
src/rename_source_table.sv
src/reorder_queue.sv
src/commit_select.sv
src/reg_valid_tracker.sv
src/scoreboard_top.sv
dv/scoreboard_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= scoreboard_tb
RTL_TOP    ?= scoreboard_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Done: no errors

.PHONY: all lint sim clean

all: lint sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -Wall --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
